// File: files.f
+incdir+include
hdl/fetch_pkg.sv
hdl/instr_mem.sv
hdl/mem_arbiter.sv
hdl/instr_decompressor.sv
hdl/branch_predictor.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
tests/fetch_tb.sv

// File: hdl/branch_predictor.sv
`timescale 1ns/10ps
`default_nettype none

module branch_predictor
    import fetch_pkg::*;
#(
    parameter int PRED_INDEX_BITS = 6
) (
    input  logic  clk,
    input  logic  reset_n,
    input  addr_t lookup_pc,
    output logic  predict_taken,
    input  logic  resolve_valid,
    input  addr_t resolve_pc,
    input  logic  resolve_taken
);

    localparam int ENTRIES = 2 ** PRED_INDEX_BITS;

    logic [1:0]                 counters [ENTRIES];
    logic [PRED_INDEX_BITS-1:0] lookup_idx;
    logic [PRED_INDEX_BITS-1:0] resolve_idx;
    logic [1:0]                 cur;

    // half-word aligned pcs, so bit 0 is skipped
    assign lookup_idx  = lookup_pc[PRED_INDEX_BITS:1];
    assign resolve_idx = resolve_pc[PRED_INDEX_BITS:1];

    assign predict_taken = counters[lookup_idx][1];
    assign cur           = counters[resolve_idx];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            // weakly not taken
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (resolve_valid) begin
            if (resolve_taken && cur != 2'b11) begin
                counters[resolve_idx] <= cur + 2'b01;
            end else if (!resolve_taken && cur != 2'b00) begin
                counters[resolve_idx] <= cur - 2'b01;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [15:0] half_t;

    // buffer state of the fetch unit
    typedef enum logic {
        DIRECT,
        USE_BUFFER
    } fetch_state_t;

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // B-type offset, sign extended
    function automatic word_t imm_b(input word_t i);
        return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
    endfunction

    // J-type offset, sign extended
    function automatic word_t imm_j(input word_t i);
        return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
    endfunction

endpackage

`default_nettype wire

// File: hdl/fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_top
    import fetch_pkg::*;
#(
    parameter int MEM_WORDS       = 1024,
    parameter int PRED_INDEX_BITS = 6
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         load_valid,
    output logic                         load_ready,
    input  logic [$clog2(MEM_WORDS)-1:0] load_addr,
    input  word_t                        load_data,
    input  logic                         start_valid,
    input  addr_t                        start_pc,
    input  logic                         redirect_valid,
    input  addr_t                        redirect_pc,
    input  logic                         resolve_valid,
    input  addr_t                        resolve_pc,
    input  logic                         resolve_taken,
    output logic                         instr_valid,
    input  logic                         instr_ready,
    output word_t                        instr,
    output addr_t                        instr_pc,
    output logic                         instr_compressed,
    output logic                         instr_illegal,
    output logic                         pred_taken
);

    localparam int MEM_AW = $clog2(MEM_WORDS);

    logic              rd_valid;
    logic              rd_ready;
    addr_t             rd_addr;
    word_t             rd_data;
    logic              rd_rvalid;
    logic              mem_we;
    logic [MEM_AW-1:0] mem_addr;
    word_t             mem_wdata;
    word_t             mem_rdata;
    half_t             parcel;
    word_t             expanded;
    logic              c_illegal;
    addr_t             lookup_pc;
    logic              predict_taken;

    instr_mem #(
        .MEM_WORDS(MEM_WORDS)
    ) u_mem (
        .clk  (clk),
        .we   (mem_we),
        .addr (mem_addr),
        .wdata(mem_wdata),
        .rdata(mem_rdata)
    );

    mem_arbiter #(
        .MEM_WORDS(MEM_WORDS)
    ) u_arbiter (
        .clk       (clk),
        .reset_n   (reset_n),
        .load_valid(load_valid),
        .load_ready(load_ready),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rd_rvalid (rd_rvalid),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    fetch_unit u_fetch (
        .clk             (clk),
        .reset_n         (reset_n),
        .start_valid     (start_valid),
        .start_pc        (start_pc),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .rd_valid        (rd_valid),
        .rd_ready        (rd_ready),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .rd_rvalid       (rd_rvalid),
        .parcel          (parcel),
        .expanded        (expanded),
        .c_illegal       (c_illegal),
        .lookup_pc       (lookup_pc),
        .predict_taken   (predict_taken),
        .instr_valid     (instr_valid),
        .instr_ready     (instr_ready),
        .instr           (instr),
        .instr_pc        (instr_pc),
        .instr_compressed(instr_compressed),
        .instr_illegal   (instr_illegal),
        .pred_taken      (pred_taken)
    );

    instr_decompressor u_decomp (
        .c_instr (parcel),
        .expanded(expanded),
        .illegal (c_illegal)
    );

    branch_predictor #(
        .PRED_INDEX_BITS(PRED_INDEX_BITS)
    ) u_pred (
        .clk          (clk),
        .reset_n      (reset_n),
        .lookup_pc    (lookup_pc),
        .predict_taken(predict_taken),
        .resolve_valid(resolve_valid),
        .resolve_pc   (resolve_pc),
        .resolve_taken(resolve_taken)
    );

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  start_valid,
    input  addr_t start_pc,
    input  logic  redirect_valid,
    input  addr_t redirect_pc,
    output logic  rd_valid,
    input  logic  rd_ready,
    output addr_t rd_addr,
    input  word_t rd_data,
    input  logic  rd_rvalid,
    output half_t parcel,
    input  word_t expanded,
    input  logic  c_illegal,
    output addr_t lookup_pc,
    input  logic  predict_taken,
    output logic  instr_valid,
    input  logic  instr_ready,
    output word_t instr,
    output addr_t instr_pc,
    output logic  instr_compressed,
    output logic  instr_illegal,
    output logic  pred_taken
);

    fetch_state_t state;
    addr_t        pc;
    half_t        half_buf;
    logic         active;

    logic  flush;
    addr_t flush_pc;
    logic  stalled;
    addr_t fetch_addr;
    logic  is_compressed;
    logic  straddle_start;
    word_t full_instr;
    word_t final_instr;
    logic  is_jal;
    logic  is_branch;
    addr_t pc_next;
    logic  deliver;

    // start behaves like a redirect
    assign flush    = redirect_valid | start_valid;
    assign flush_pc = redirect_valid ? redirect_pc : start_pc;
    assign stalled  = instr_valid & ~instr_ready;

    // second half of a straddling instruction lives in the next word
    assign fetch_addr = (state == USE_BUFFER) ? pc + 32'd2 : pc;
    assign rd_addr    = {fetch_addr[31:2], 2'b00};

    // one read in flight, and only when the output slot will be free
    assign rd_valid = active & ~rd_rvalid & ~stalled & ~flush;

    // parcel selection
    always_comb begin
        is_compressed  = 1'b0;
        straddle_start = 1'b0;
        parcel         = rd_data[15:0];
        full_instr     = rd_data;
        if (state == USE_BUFFER) begin
            full_instr = {rd_data[15:0], half_buf};
        end else if (pc[1]) begin
            parcel         = rd_data[31:16];
            is_compressed  = rd_data[17:16] != 2'b11;
            straddle_start = rd_data[17:16] == 2'b11;
        end else begin
            is_compressed = rd_data[1:0] != 2'b11;
        end
        final_instr = is_compressed ? expanded : full_instr;
    end

    assign is_jal    = final_instr[6:0] == OPC_JAL;
    assign is_branch = final_instr[6:0] == OPC_BRANCH;
    assign lookup_pc = pc;

    // next pc with jumps always taken and branches by the counter
    always_comb begin
        if (is_jal) begin
            pc_next = pc + imm_j(final_instr);
        end else if (is_branch && predict_taken) begin
            pc_next = pc + imm_b(final_instr);
        end else begin
            pc_next = pc + (is_compressed ? 32'd2 : 32'd4);
        end
    end

    assign deliver = rd_rvalid & ~flush & ~straddle_start;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= DIRECT;
            pc          <= '0;
            active      <= 1'b0;
            instr_valid <= 1'b0;
        end else if (flush) begin
            // in-flight data returning now is dropped
            state       <= DIRECT;
            pc          <= flush_pc;
            active      <= 1'b1;
            instr_valid <= 1'b0;
        end else begin
            if (instr_valid && instr_ready) begin
                instr_valid <= 1'b0;
            end
            if (rd_rvalid) begin
                if (straddle_start) begin
                    state <= USE_BUFFER;
                end else begin
                    state       <= DIRECT;
                    pc          <= pc_next;
                    instr_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_rvalid && straddle_start) begin
            half_buf <= rd_data[31:16];
        end
        if (deliver) begin
            instr            <= final_instr;
            instr_pc         <= pc;
            instr_compressed <= is_compressed;
            instr_illegal    <= is_compressed & c_illegal;
            pred_taken       <= is_branch & predict_taken;
        end
    end

    // outputs hold until taken, unless flushed
    assert property (@(posedge clk) disable iff (!reset_n)
        stalled && !flush |=> instr_valid && $stable(instr) && $stable(instr_pc))
        else $error("output changed under back-pressure");

    // read data from the memory always finds the output slot free
    assert property (@(posedge clk) disable iff (!reset_n) rd_rvalid && !flush |-> !stalled)
        else $error("read data returned into a full output register");

endmodule

`default_nettype wire

// File: hdl/instr_decompressor.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decompressor
    import fetch_pkg::*;
(
    input  half_t c_instr,
    output word_t expanded,
    output logic  illegal
);

    logic [1:0]  quadrant;
    logic [2:0]  funct3;
    logic [4:0]  rd_full;
    logic [4:0]  rs2_full;
    logic [4:0]  rs1_short;
    logic [4:0]  rd_short;
    logic [11:0] imm_ci;
    logic [11:0] imm_lsw;
    logic [20:0] imm_cj;
    logic [12:0] imm_cb;

    assign quadrant = c_instr[1:0];
    assign funct3   = c_instr[15:13];
    assign rd_full  = c_instr[11:7];
    assign rs2_full = c_instr[6:2];

    // three-bit register fields map to x8..x15
    assign rs1_short = {2'b01, c_instr[9:7]};
    assign rd_short  = {2'b01, c_instr[4:2]};

    // CI immediate, also the upper bits of c.lui
    assign imm_ci = {{6{c_instr[12]}}, c_instr[12], c_instr[6:2]};

    // word offset of c.lw / c.sw
    assign imm_lsw = {5'b0, c_instr[5], c_instr[12:10], c_instr[6], 2'b00};

    assign imm_cj = {{9{c_instr[12]}}, c_instr[12], c_instr[8], c_instr[10:9],
                     c_instr[6], c_instr[7], c_instr[2], c_instr[11], c_instr[5:3], 1'b0};

    assign imm_cb = {{4{c_instr[12]}}, c_instr[12], c_instr[6:5], c_instr[2],
                     c_instr[11:10], c_instr[4:3], 1'b0};

    always_comb begin
        expanded = '0;
        illegal  = 1'b0;
        // the all-zero parcel lands in the default branch
        case ({quadrant, funct3})
            // c.lw
            5'b00_010: begin
                expanded = {imm_lsw, rs1_short, 3'b010, rd_short, 7'b0000011};
            end
            // c.sw
            5'b00_110: begin
                expanded = {imm_lsw[11:5], rd_short, rs1_short, 3'b010,
                            imm_lsw[4:0], 7'b0100011};
            end
            // c.addi and c.nop
            5'b01_000: begin
                expanded = {imm_ci, rd_full, 3'b000, rd_full, 7'b0010011};
            end
            // c.li
            5'b01_010: begin
                expanded = {imm_ci, 5'd0, 3'b000, rd_full, 7'b0010011};
            end
            // c.lui, rd x2 is c.addi16sp and not supported
            5'b01_011: begin
                if (rd_full != 5'd2 && imm_ci != '0) begin
                    expanded = {{8{imm_ci[11]}}, imm_ci, rd_full, 7'b0110111};
                end else begin
                    illegal = 1'b1;
                end
            end
            // c.j
            5'b01_101: begin
                expanded = {imm_cj[20], imm_cj[10:1], imm_cj[11], imm_cj[19:12],
                            5'd0, OPC_JAL};
            end
            // c.beqz / c.bnez, funct3 bit 0 picks bne
            5'b01_110, 5'b01_111: begin
                expanded = {imm_cb[12], imm_cb[10:5], 5'd0, rs1_short,
                            {2'b00, funct3[0]}, imm_cb[4:1], imm_cb[11], OPC_BRANCH};
            end
            // c.mv and c.add, rs2 of zero would be c.jr / c.jalr
            5'b10_100: begin
                if (rs2_full == 5'd0) begin
                    illegal = 1'b1;
                end else if (c_instr[12]) begin
                    expanded = {7'b0, rs2_full, rd_full, 3'b000, rd_full, 7'b0110011};
                end else begin
                    expanded = {7'b0, rs2_full, 5'd0, 3'b000, rd_full, 7'b0110011};
                end
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/instr_mem.sv
`timescale 1ns/10ps
`default_nettype none

module instr_mem
    import fetch_pkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    input  logic                         clk,
    input  logic                         we,
    input  logic [$clog2(MEM_WORDS)-1:0] addr,
    input  word_t                        wdata,
    output word_t                        rdata
);

    word_t mem [MEM_WORDS];

    // read data is registered, so it shows up one cycle after addr
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: hdl/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
    import fetch_pkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         load_valid,
    output logic                         load_ready,
    input  logic [$clog2(MEM_WORDS)-1:0] load_addr,
    input  word_t                        load_data,
    input  logic                         rd_valid,
    output logic                         rd_ready,
    input  addr_t                        rd_addr,
    output word_t                        rd_data,
    output logic                         rd_rvalid,
    output logic                         mem_we,
    output logic [$clog2(MEM_WORDS)-1:0] mem_addr,
    output word_t                        mem_wdata,
    input  word_t                        mem_rdata
);

    localparam int MEM_AW = $clog2(MEM_WORDS);

    logic rd_pending;

    // loader always wins
    assign load_ready = 1'b1;
    assign mem_we     = load_valid & load_ready;
    assign rd_ready   = rd_valid & ~load_valid;

    assign mem_addr  = mem_we ? load_addr : rd_addr[MEM_AW+1:2];
    assign mem_wdata = load_data;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= rd_valid & rd_ready;
        end
    end

    assign rd_data   = mem_rdata;
    assign rd_rvalid = rd_pending;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module fetch_tb -o fetch_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/fetch_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0

// File: include/fetch_model.svh
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

// reference program image and predictor state, indexed by half-word
localparam int PROG_INSTR = 120;
localparam int HALVES     = 2 * MEM_WORDS;

half_t      img [HALVES];
word_t      exp_word [HALVES];
logic       exp_comp [HALVES];
logic       exp_ill [HALVES];
// 0 plain, 1 jump, 2 conditional branch
logic [1:0] ctl [HALVES];
int         step_off [HALVES];
int         starts [PROG_INSTR];
logic [1:0] cnt [2 ** PRED_INDEX_BITS];
int         prog_halves;

function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
endfunction

function automatic word_t enc_jal(input int off, input logic [4:0] rd);
    logic [20:0] o;
    o = off[20:0];
    return {o[20], o[10:1], o[11], o[19:12], rd, OPC_JAL};
endfunction

function automatic word_t enc_br(input int off, input logic [2:0] f3,
                                 input logic [4:0] rs1, input logic [4:0] rs2);
    logic [12:0] o;
    o = off[12:0];
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], OPC_BRANCH};
endfunction

task automatic place(input int i, input half_t p, input word_t w, input logic comp,
                     input logic ill, input logic [1:0] c, input int off);
    int h;
    h = starts[i] / 2;
    img[h] = comp ? p : w[15:0];
    if (!comp) begin
        img[h + 1] = w[31:16];
    end
    exp_word[h] = w;
    exp_comp[h] = comp;
    exp_ill[h]  = ill;
    ctl[h]      = c;
    step_off[h] = off;
endtask

// random mix at half-word alignment closed by a jal back to address 0
task automatic build_program();
    int          kinds [PROG_INSTR];
    int          addr;
    int          t;
    int          off;
    logic [20:0] o;
    logic [5:0]  imm;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [2:0]  rs;
    logic [2:0]  rdc;
    logic        f;
    word_t       w;
    addr = 0;
    for (int h = 0; h < HALVES; h++) begin
        img[h] = '0;
    end
    for (int i = 0; i < 2 ** PRED_INDEX_BITS; i++) begin
        cnt[i] = 2'b01;
    end
    for (int i = 0; i < PROG_INSTR; i++) begin
        kinds[i] = (i < 8) ? 0 : rnd(13);
        if (i == PROG_INSTR - 1) begin
            kinds[i] = 2;
        end
        starts[i] = addr;
        addr += (kinds[i] >= 3) ? 2 : 4;
    end
    prog_halves = addr / 2;
    for (int i = 0; i < PROG_INSTR; i++) begin
        t = i + 1 + rnd(4);
        if (t > PROG_INSTR - 1) begin
            t = PROG_INSTR - 1;
        end
        off = (i == PROG_INSTR - 1) ? -starts[i] : starts[t] - starts[i];
        o   = off[20:0];
        imm = 6'(rnd(64));
        rd  = 5'(rnd(32));
        rs2 = 5'(1 + rnd(31));
        rs  = 3'(rnd(8));
        rdc = 3'(rnd(8));
        f   = 1'(rnd(2));
        w   = $random(seed);
        case (kinds[i])
            0: place(i, '0, {w[31:7], 7'b0010011}, 1'b0, 1'b0, 2'd0, 0);
            1: place(i, '0, enc_br(off, {2'b00, f}, w[19:15], w[24:20]), 1'b0, 1'b0, 2'd2, off);
            2: place(i, '0, enc_jal(off, rd), 1'b0, 1'b0, 2'd1, off);
            3: place(i, {3'b000, imm[5], rd, imm[4:0], 2'b01},
                     {{6{imm[5]}}, imm, rd, 3'b000, rd, 7'b0010011}, 1'b1, 1'b0, 2'd0, 0);
            4: place(i, {3'b010, imm[5], rd, imm[4:0], 2'b01},
                     {{6{imm[5]}}, imm, 5'd0, 3'b000, rd, 7'b0010011}, 1'b1, 1'b0, 2'd0, 0);
            5: place(i, {4'b1000, rd, rs2, 2'b10},
                     {7'b0, rs2, 5'd0, 3'b000, rd, 7'b0110011}, 1'b1, 1'b0, 2'd0, 0);
            6: place(i, {4'b1001, rd, rs2, 2'b10},
                     {7'b0, rs2, rd, 3'b000, rd, 7'b0110011}, 1'b1, 1'b0, 2'd0, 0);
            // c.lw with imm[4:0] as the word offset
            7: place(i, {3'b010, imm[3:1], rs, imm[0], imm[4], rdc, 2'b00},
                     {5'b0, imm[4:0], 2'b00, 2'b01, rs, 3'b010, 2'b01, rdc, 7'b0000011},
                     1'b1, 1'b0, 2'd0, 0);
            8: place(i, {3'b101, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01},
                     enc_jal(off, 5'd0), 1'b1, 1'b0, 2'd1, off);
            9: place(i, {2'b11, f, o[8], o[4:3], rs, o[7:6], o[2:1], o[5], 2'b01},
                     enc_br(off, {2'b00, f}, {2'b01, rs}, 5'd0), 1'b1, 1'b0, 2'd2, off);
            // odd rd and odd imm keep c.lui clear of c.addi16sp and the reserved zero
            10: place(i, {3'b011, imm[5], rd[4:1], 1'b1, imm[4:1], 1'b1, 2'b01},
                      {{14{imm[5]}}, imm[5:1], 1'b1, rd[4:1], 1'b1, 7'b0110111},
                      1'b1, 1'b0, 2'd0, 0);
            // c.sw with the same offset layout as c.lw
            11: place(i, {3'b110, imm[3:1], rs, imm[0], imm[4], rdc, 2'b00},
                      {5'b0, imm[4:3], 2'b01, rdc, 2'b01, rs, 3'b010, imm[2:0], 2'b00,
                       7'b0100011}, 1'b1, 1'b0, 2'd0, 0);
            default: place(i, '0, '0, 1'b1, 1'b1, 2'd0, 0);
        endcase
    end
endtask

task automatic train(input addr_t pc, input logic taken);
    logic [1:0] c;
    c = cnt[pc[PRED_INDEX_BITS:1]];
    if (taken && c != 2'd3) begin
        c = c + 2'd1;
    end else if (!taken && c != 2'd0) begin
        c = c - 2'd1;
    end
    cnt[pc[PRED_INDEX_BITS:1]] = c;
endtask

`endif

// File: tests/fetch_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam int MEM_WORDS       = 1024;
    localparam int PRED_INDEX_BITS = 6;
    localparam int MEM_AW          = $clog2(MEM_WORDS);
    localparam int N_INSTR         = 400;

    logic              clk;
    logic              reset_n;
    logic              load_valid;
    logic              load_ready;
    logic [MEM_AW-1:0] load_addr;
    word_t             load_data;
    logic              start_valid;
    addr_t             start_pc;
    logic              redirect_valid;
    addr_t             redirect_pc;
    logic              resolve_valid;
    addr_t             resolve_pc;
    logic              resolve_taken;
    logic              instr_valid;
    logic              instr_ready;
    word_t             instr;
    addr_t             instr_pc;
    logic              instr_compressed;
    logic              instr_illegal;
    logic              pred_taken;

    integer seed = 32'hb069;
    addr_t  mpc;
    addr_t  exp_next;
    logic   exp_pred;
    int     delivered;
    logic   held;
    word_t  held_instr;
    addr_t  held_pc;

    `include "fetch_model.svh"

    fetch_top #(
        .MEM_WORDS      (MEM_WORDS),
        .PRED_INDEX_BITS(PRED_INDEX_BITS)
    ) dut (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check_eq(input string what, input word_t got, input word_t want);
        assert (got == want) else begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // prediction and successor are frozen when the instruction becomes next
    task automatic expect_at(input addr_t pc);
        int h;
        h        = pc / 2;
        mpc      = pc;
        exp_pred = ctl[h] == 2'd2 && cnt[pc[PRED_INDEX_BITS:1]][1];
        if (ctl[h] == 2'd1 || exp_pred) begin
            exp_next = pc + step_off[h];
        end else begin
            exp_next = pc + (exp_comp[h] ? 2 : 4);
        end
    endtask

    initial begin
        #((40 * N_INSTR + MEM_WORDS + 64) * 4);
        $display("watchdog expired before all instructions arrived");
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        logic  redir;
        logic  stall;
        logic  res;
        logic  rt;
        addr_t target;
        addr_t rpc;
        reset_n        <= 1'b0;
        load_valid     <= 1'b0;
        load_addr      <= '0;
        load_data      <= '0;
        start_valid    <= 1'b0;
        start_pc       <= '0;
        redirect_valid <= 1'b0;
        redirect_pc    <= '0;
        resolve_valid  <= 1'b0;
        resolve_pc     <= '0;
        resolve_taken  <= 1'b0;
        instr_ready    <= 1'b0;
        delivered = 0;
        held      = 1'b0;
        build_program();
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        for (int w = 0; w < (prog_halves + 1) / 2; w++) begin
            @(posedge clk);
            load_valid <= 1'b1;
            load_addr  <= MEM_AW'(w);
            load_data  <= {img[2 * w + 1], img[2 * w]};
            do @(negedge clk); while (!load_ready);
        end
        @(posedge clk);
        load_valid  <= 1'b0;
        start_valid <= 1'b1;
        start_pc    <= '0;
        expect_at('0);
        @(posedge clk);
        start_valid <= 1'b0;

        while (delivered < N_INSTR) begin
            @(negedge clk);
            if (held) begin
                check_eq("instr_valid under stall", 32'(instr_valid), 1);
                check_eq("instr under stall", instr, held_instr);
                check_eq("instr_pc under stall", instr_pc, held_pc);
            end
            if (instr_valid && instr_ready) begin
                check_eq("instr_pc", instr_pc, mpc);
                check_eq("instr", instr, exp_word[mpc / 2]);
                check_eq("instr_compressed", 32'(instr_compressed), 32'(exp_comp[mpc / 2]));
                check_eq("instr_illegal", 32'(instr_illegal), 32'(exp_ill[mpc / 2]));
                check_eq("pred_taken", 32'(pred_taken), 32'(exp_pred));
                delivered++;
                expect_at(exp_next);
            end
            held       = instr_valid && !instr_ready && !redirect_valid;
            held_instr = instr;
            held_pc    = instr_pc;

            redir  = rnd(50) == 0;
            stall  = rnd(3) == 0;
            // train only while the output is stalled, so no lookup is in flight
            res    = !redir && !redirect_valid && instr_valid && !instr_ready && rnd(2) == 0;
            target = starts[rnd(PROG_INSTR)];
            rpc    = starts[rnd(PROG_INSTR)];
            rt     = rnd(3) != 0;
            if (redir) begin
                expect_at(target);
            end
            if (res) begin
                train(rpc, rt);
            end

            @(posedge clk);
            instr_ready    <= !(stall || redir || res);
            redirect_valid <= redir;
            redirect_pc    <= target;
            resolve_valid  <= res;
            resolve_pc     <= rpc;
            resolve_taken  <= rt;
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
